/* tb.f */
+incdir+design
design/vic_pkg.sv
design/vic_phase_gen.sv
design/vic_raster.sv
design/vic_registers.sv
design/vic_bus_arbiter.sv
design/vic_timing_top.sv
sim/tb_clock.sv
sim/tb_vic_timing.sv

/* Makefile */
TOP := tb_vic_timing

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* sim/tb_vic_timing.sv */
`timescale 1ns/1ns

`include "vic_settings.svh"

module tb_vic_timing;

   // longest frame is 504 x 312 dots at 4 cycles each
   localparam int frame_cycles = 700000;

   logic                  clk_dot4x;
   logic                  por;
   logic                  rst_req;
   logic                  rst;
   logic                  rst_edge;
   vic_pkg::chip_e        chip;
   logic                  ce;
   logic                  rw;
   logic [5:0]            adi;
   logic [7:0]            dbi;
   logic                  clk_phi;
   vic_pkg::raster_x_t    raster_x;
   vic_pkg::raster_line_t raster_line;
   logic                  irq;
   logic                  ba;
   logic                  aec;
   logic [7:0]            dbo;

   // reference model state
   int                    k;
   vic_pkg::raster_x_t    m_x;
   vic_pkg::raster_line_t m_line;
   vic_pkg::raster_line_t m_cmp;
   logic [2:0]            m_ysc;
   logic                  m_den;
   logic                  m_erst;
   logic                  m_irst;
   logic                  m_trig;
   logic                  m_irq;
   logic                  m_allow;
   logic                  m_aec;
   logic [7:0]            m_dbo;
   int                    m_hold;
   logic                  last_write;
   logic                  model_valid = 1'b0;
   int                    ba_low_count;

   tb_clock tb_clock_i (
      .clk_o (clk_dot4x),
      .por_o (por)
   );

   assign rst = por | rst_req;

   // reset as seen by the dut on each edge
   always @(posedge clk_dot4x) rst_edge <= rst;

   vic_timing_top vic_timing_top_i (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .chip_i        (chip),
      .ce_i          (ce),
      .rw_i          (rw),
      .adi_i         (adi),
      .dbi_i         (dbi),
      .clk_phi_o     (clk_phi),
      .raster_x_o    (raster_x),
      .raster_line_o (raster_line),
      .irq_o         (irq),
      .ba_o          (ba),
      .aec_o         (aec),
      .dbo_o         (dbo)
   );

   task automatic stop_run();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_raster(input vic_pkg::raster_x_t exp_x, input vic_pkg::raster_line_t exp_l,
                               input vic_pkg::raster_x_t act_x, input vic_pkg::raster_line_t act_l);
      if (act_x !== exp_x) begin
         $display("error at %0t: raster_x_o expected %0d got %0d", $time, exp_x, act_x);
         stop_run();
      end
      if (act_l !== exp_l) begin
         $display("error at %0t: raster_line_o expected %0d got %0d", $time, exp_l, act_l);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("error at %0t: %s expected %b got %b", $time, name, expected, actual);
         stop_run();
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] expected, input logic [7:0] actual);
      if (actual !== expected) begin
         $display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
         stop_run();
      end
   endtask

   // phi is high for 16 cycles starting 12 cycles after reset
   function automatic logic phi_at(input int kk);
      return (kk % 32) >= 12 && (kk % 32) <= 27;
   endfunction

   function automatic vic_pkg::raster_x_t x_limit(input vic_pkg::chip_e c);
      case (c)
         vic_pkg::chip_6567r8:   return vic_pkg::raster_x_t'(`VIC_R8_X_MAX);
         vic_pkg::chip_6567r56a: return vic_pkg::raster_x_t'(`VIC_R56A_X_MAX);
         default:                return vic_pkg::raster_x_t'(`VIC_6569_X_MAX);
      endcase
   endfunction

   function automatic vic_pkg::raster_line_t y_limit(input vic_pkg::chip_e c);
      case (c)
         vic_pkg::chip_6567r8:   return vic_pkg::raster_line_t'(`VIC_R8_Y_MAX);
         vic_pkg::chip_6567r56a: return vic_pkg::raster_line_t'(`VIC_R56A_Y_MAX);
         default:                return vic_pkg::raster_line_t'(`VIC_6569_Y_MAX);
      endcase
   endfunction

   // ba low only on a badline inside the character cycle window
   function automatic logic model_ba();
      logic badline;
      int   cycle;
      badline = m_allow && (m_line[2:0] == m_ysc)
             && (m_line >= `VIC_BADLINE_FIRST) && (m_line < `VIC_BADLINE_END);
      cycle = int'(m_x) / 8;
      return !(badline && cycle >= `VIC_BA_FIRST_CYCLE && cycle <= `VIC_BA_LAST_CYCLE);
   endfunction

   function automatic logic [7:0] read_value(input logic [5:0] addr);
      case (addr)
         vic_pkg::reg_ctrl1:  return {m_line[8], 2'b00, m_den, 1'b0, m_ysc};
         vic_pkg::reg_raster: return m_line[7:0];
         vic_pkg::reg_irq:    return {m_irq, 6'b000000, m_irst};
         vic_pkg::reg_irq_en: return {7'b0000000, m_erst};
         default:             return 8'hff;
      endcase
   endfunction

   // advance the model across one clock edge, old values first
   task automatic update_model();
      logic       phi;
      logic       dot;
      logic       ba_now;
      logic       wr;
      logic [7:0] rd;
      if (rst_edge) begin
         k           = 0;
         m_x         = '0;
         m_line      = '0;
         m_cmp       = '0;
         m_ysc       = '0;
         m_den       = 1'b0;
         m_erst      = 1'b0;
         m_irst      = 1'b0;
         m_trig      = 1'b0;
         m_irq       = 1'b0;
         m_allow     = 1'b0;
         m_aec       = 1'b0;
         m_dbo       = '0;
         m_hold      = 0;
         last_write  = 1'b0;
         model_valid = 1'b1;
      end else begin
         phi    = phi_at(k);
         // dot tick lands one cycle after reset release, then every 4
         dot    = (k % 4) == 1;
         wr     = phi && ((k % 32) == 12 + `VIC_DATA_DAV) && !ce && !rw;
         ba_now = model_ba();
         rd     = read_value(adi);
         // m_hold counts phi rises in a row with ba low
         m_aec  = ba_now ? phi : (phi && m_hold < `VIC_AEC_DELAY);
         if ((k % 32) == 12) begin
            if (ba_now)
               m_hold = 0;
            else if (m_hold < `VIC_AEC_DELAY)
               m_hold++;
            if (m_line == `VIC_BADLINE_FIRST && m_den)
               m_allow = 1'b1;
            if (m_line == `VIC_BADLINE_END)
               m_allow = 1'b0;
         end
         m_irq = m_irst && m_erst;
         if (dot) begin
            if (m_line != m_cmp) begin
               m_trig = 1'b0;
            end else if (!m_trig) begin
               m_trig = 1'b1;
               m_irst = 1'b1;
            end
         end
         if (wr) begin
            case (adi)
               vic_pkg::reg_ctrl1: begin
                  m_ysc    = dbi[2:0];
                  m_den    = dbi[4];
                  m_cmp[8] = dbi[7];
               end
               vic_pkg::reg_raster: m_cmp[7:0] = dbi;
               vic_pkg::reg_irq:    m_irst = m_irst && !dbi[0];
               vic_pkg::reg_irq_en: m_erst = dbi[0];
               default: ;
            endcase
         end
         if (dot) begin
            if (m_x == x_limit(chip)) begin
               m_x    = '0;
               m_line = (m_line == y_limit(chip)) ? 9'd0 : m_line + 9'd1;
            end else begin
               m_x = m_x + 10'd1;
            end
         end
         m_dbo      = rd;
         last_write = wr;
         k++;
      end
   endtask

   // one clock, then model update and compare before new stimulus
   task automatic tick();
      @(posedge clk_dot4x);
      #1;
      update_model();
      if (model_valid) begin
         check_raster(m_x, m_line, raster_x, raster_line);
         check_flag("clk_phi_o", phi_at(k), clk_phi);
         check_flag("irq_o", m_irq, irq);
         check_flag("ba_o", model_ba(), ba);
         check_flag("aec_o", m_aec, aec);
         check_byte("dbo_o", m_dbo, dbo);
         if (!ba)
            ba_low_count++;
      end
   endtask

   task automatic apply_reset(input vic_pkg::chip_e next_chip);
      rst_req = 1'b1;
      chip    = next_chip;
      tick();
      tick();
      rst_req = 1'b0;
   endtask

   // hold the write strobe until a phi-high capture edge passes
   task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
      int guard;
      ce    = 1'b0;
      rw    = 1'b0;
      adi   = addr;
      dbi   = data;
      guard = 0;
      do begin
         tick();
         guard++;
         if (guard > 40) begin
            $display("write to register %h was never captured", addr);
            stop_run();
         end
      end while (!last_write);
      ce = 1'b1;
      rw = 1'b1;
   endtask

   task automatic bus_read(input logic [5:0] addr, input logic [7:0] expected);
      ce  = 1'b0;
      rw  = 1'b1;
      adi = addr;
      tick();
      tick();
      check_byte("dbo_o", expected, dbo);
      ce = 1'b1;
   endtask

   task automatic run_until_line(input vic_pkg::raster_line_t line);
      int guard;
      guard = 0;
      while (raster_line !== line) begin
         tick();
         guard++;
         if (guard > frame_cycles) begin
            $display("raster line %0d was never reached", line);
            stop_run();
         end
      end
   endtask

   // one frame per chip: bus noise, setup, raster irq, then wrap
   task automatic run_chip(input vic_pkg::chip_e c, input logic den_set, input logic irq_en);
      vic_pkg::raster_line_t cmp_line;
      logic [2:0]            ysc;
      int unsigned           span;
      int                    guard;
      apply_reset(c);
      repeat (300) begin
         ce  = 1'($urandom % 2);
         rw  = 1'($urandom % 2);
         dbi = 8'($urandom);
         case ($urandom % 4)
            0:       adi = vic_pkg::reg_ctrl1;
            1:       adi = vic_pkg::reg_raster;
            2:       adi = vic_pkg::reg_irq_en;
            default: adi = 6'($urandom);
         endcase
         tick();
      end
      ce   = 1'b1;
      rw   = 1'b1;
      span = int'(y_limit(c)) - 1;
      cmp_line = vic_pkg::raster_line_t'(32'd2 + $urandom % span);
      ysc  = 3'($urandom % 8);
      bus_write(vic_pkg::reg_raster, cmp_line[7:0]);
      bus_write(vic_pkg::reg_ctrl1, {cmp_line[8], 2'b00, den_set, 1'b0, ysc});
      bus_write(vic_pkg::reg_irq, 8'h01);
      bus_write(vic_pkg::reg_irq_en, {7'b0000000, irq_en});
      ba_low_count = 0;
      run_until_line(cmp_line);
      if (irq_en) begin
         guard = 0;
         while (irq !== 1'b1) begin
            tick();
            guard++;
            if (guard > 6) begin
               $display("irq_o did not rise within 6 cycles of compare line %0d", cmp_line);
               stop_run();
            end
         end
         repeat (50 + $urandom % 200) tick();
         check_flag("irq_o", 1'b1, irq);
         bus_write(vic_pkg::reg_irq, 8'h01);
         tick();
         check_flag("irq_o", 1'b0, irq);
      end else begin
         repeat (8) tick();
         // latch visible, irq itself stays low
         bus_read(vic_pkg::reg_irq, 8'h01);
         bus_write(vic_pkg::reg_irq, 8'h01);
      end
      run_until_line(y_limit(c));
      run_until_line(9'd0);
      check_flag("ba_o activity", den_set, ba_low_count != 0);
   endtask

   initial begin
      int order[4];
      int j;
      int tmp;
      void'($urandom(32'h403887e4));
      rst_req = 1'b0;
      chip    = vic_pkg::chip_6569;
      ce      = 1'b1;
      rw      = 1'b1;
      adi     = '0;
      dbi     = '0;
      ba_low_count = 0;
      for (int i = 0; i < 4; i++)
         order[i] = i;
      // shuffle the chip codes
      for (int i = 3; i > 0; i--) begin
         j        = int'($urandom % (i + 1));
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      // den and irq enable cover all four combinations
      for (int i = 0; i < 4; i++)
         run_chip(vic_pkg::chip_e'(order[i]), i[0], i[1]);
      $display("sim passed");
      $finish;
   end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
   output logic clk_o,
   output logic por_o
);

   // 8 ns dot4x period
   initial begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;
   end

   // power-on reset over the first two rising edges
   initial begin
      por_o = 1'b1;
      repeat (2) @(posedge clk_o);
      #1 por_o = 1'b0;
   end

endmodule

/* design/vic_timing_top.sv */
`timescale 1ns/1ns

module vic_timing_top (
   input  logic                  clk_dot4x,
   input  logic                  rst,
   input  vic_pkg::chip_e        chip_i,
   input  logic                  ce_i,
   input  logic                  rw_i,
   input  logic [5:0]            adi_i,
   input  logic [7:0]            dbi_i,
   output logic                  clk_phi_o,
   output vic_pkg::raster_x_t    raster_x_o,
   output vic_pkg::raster_line_t raster_line_o,
   output logic                  irq_o,
   output logic                  ba_o,
   output logic                  aec_o,
   output logic [7:0]            dbo_o
);

   logic       dot_tick;
   logic       phi_rise;
   logic [3:0] phase_tick;
   logic [2:0] yscroll;
   logic       den;

   // phi, dot tick and phase position
   vic_phase_gen vic_phase_gen_i (
      .clk_dot4x    (clk_dot4x),
      .rst          (rst),
      .clk_phi_o    (clk_phi_o),
      .dot_tick_o   (dot_tick),
      .phi_rise_o   (phi_rise),
      .phase_tick_o (phase_tick)
   );

   vic_raster vic_raster_i (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .chip_i        (chip_i),
      .dot_tick_i    (dot_tick),
      .raster_x_o    (raster_x_o),
      .raster_line_o (raster_line_o)
   );

   // cpu side, raster irq
   vic_registers vic_registers_i (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .clk_phi_i     (clk_phi_o),
      .phase_tick_i  (phase_tick),
      .dot_tick_i    (dot_tick),
      .ce_i          (ce_i),
      .rw_i          (rw_i),
      .adi_i         (adi_i),
      .dbi_i         (dbi_i),
      .raster_line_i (raster_line_o),
      .yscroll_o     (yscroll),
      .den_o         (den),
      .irq_o         (irq_o),
      .dbo_o         (dbo_o)
   );

   // badline ba and aec hold-off
   vic_bus_arbiter vic_bus_arbiter_i (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .clk_phi_i     (clk_phi_o),
      .phi_rise_i    (phi_rise),
      .raster_x_i    (raster_x_o),
      .raster_line_i (raster_line_o),
      .yscroll_i     (yscroll),
      .den_i         (den),
      .ba_o          (ba_o),
      .aec_o         (aec_o)
   );

endmodule

/* design/vic_bus_arbiter.sv */
`timescale 1ns/1ns

`include "vic_settings.svh"

module vic_bus_arbiter (
   input  logic                  clk_dot4x,
   input  logic                  rst,
   input  logic                  clk_phi_i,
   input  logic                  phi_rise_i,
   input  vic_pkg::raster_x_t    raster_x_i,
   input  vic_pkg::raster_line_t raster_line_i,
   input  logic [2:0]            yscroll_i,
   input  logic                  den_i,
   output logic                  ba_o,
   output logic                  aec_o
);

   vic_pkg::cycle_num_t        cycle_num;
   logic                       allow_bad_lines_q;
   logic                       badline;
   logic                       in_window;
   logic                       ba;
   // ba history sampled at each phi rise, last stage gates aec
   logic [`VIC_AEC_DELAY-1:0]  ba_stage_q;
   logic                       aec_q;

   // 8 pixels per cycle
   assign cycle_num = vic_pkg::cycle_num_t'(raster_x_i[9:3]);

   // den only counts on the first badline line
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines_q <= 1'b0;
      end else if (phi_rise_i) begin
         if (raster_line_i == vic_pkg::raster_line_t'(`VIC_BADLINE_FIRST) && den_i)
            allow_bad_lines_q <= 1'b1;
         if (raster_line_i == vic_pkg::raster_line_t'(`VIC_BADLINE_END))
            allow_bad_lines_q <= 1'b0;
      end
   end

   assign badline = allow_bad_lines_q
                 && (raster_line_i[2:0] == yscroll_i)
                 && (raster_line_i >= vic_pkg::raster_line_t'(`VIC_BADLINE_FIRST))
                 && (raster_line_i < vic_pkg::raster_line_t'(`VIC_BADLINE_END));

   // character fetch window, includes the 3 cycle ba lead
   assign in_window = (cycle_num >= vic_pkg::cycle_num_t'(`VIC_BA_FIRST_CYCLE))
                   && (cycle_num <= vic_pkg::cycle_num_t'(`VIC_BA_LAST_CYCLE));

   assign ba = !(badline && in_window);

   // once ba is low, each stage goes low one phi rise later
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba_stage_q <= '1;
      end else if (phi_rise_i) begin
         ba_stage_q[0] <= ba;
         for (int i = 1; i < `VIC_AEC_DELAY; i++)
            ba_stage_q[i] <= ba_stage_q[i-1] | ba;
      end
   end

   // cpu owns phi high unless ba has been low long enough
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         aec_q <= 1'b0;
      else
         aec_q <= ba ? clk_phi_i : (clk_phi_i & ba_stage_q[`VIC_AEC_DELAY-1]);
   end

   assign ba_o  = ba;
   assign aec_o = aec_q;

endmodule

/* design/vic_registers.sv */
`timescale 1ns/1ns

`include "vic_settings.svh"

module vic_registers (
   input  logic                  clk_dot4x,
   input  logic                  rst,
   input  logic                  clk_phi_i,
   input  logic [3:0]            phase_tick_i,
   input  logic                  dot_tick_i,
   input  logic                  ce_i,
   input  logic                  rw_i,
   input  logic [5:0]            adi_i,
   input  logic [7:0]            dbi_i,
   input  vic_pkg::raster_line_t raster_line_i,
   output logic [2:0]            yscroll_o,
   output logic                  den_o,
   output logic                  irq_o,
   output logic [7:0]            dbo_o
);

   vic_pkg::reg_addr_e    addr;
   vic_pkg::raster_line_t raster_cmp_q;
   logic [2:0]            yscroll_q;
   logic                  den_q;
   // raster irq latch, enable, and once-per-line flag
   logic                  irst_q;
   logic                  erst_q;
   logic                  triggered_q;
   logic                  irq_q;
   logic                  wr_en;
   logic                  irst_clr;
   logic [7:0]            rd_data;
   logic [7:0]            dbo_q;

   assign addr = vic_pkg::reg_addr_e'(adi_i);

   // one capture per phi-high half, once data has settled
   assign wr_en = clk_phi_i && (phase_tick_i == 4'(`VIC_DATA_DAV)) && !ce_i && !rw_i;
   assign irst_clr = wr_en && (addr == vic_pkg::reg_irq) && dbi_i[0];

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         yscroll_q    <= '0;
         den_q        <= 1'b0;
         raster_cmp_q <= '0;
         erst_q       <= 1'b0;
      end else if (wr_en) begin
         case (addr)
            vic_pkg::reg_ctrl1: begin
               yscroll_q       <= dbi_i[2:0];
               den_q           <= dbi_i[4];
               // bit 7 is the compare msb
               raster_cmp_q[8] <= dbi_i[7];
            end
            vic_pkg::reg_raster: raster_cmp_q[7:0] <= dbi_i;
            vic_pkg::reg_irq_en: erst_q <= dbi_i[0];
            default: ;
         endcase
      end
   end

   // latch once per line on a compare match, cpu clears it via $19
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst_q      <= 1'b0;
         triggered_q <= 1'b0;
         irq_q       <= 1'b0;
      end else begin
         if (dot_tick_i) begin
            if (raster_line_i == raster_cmp_q) begin
               if (!triggered_q) begin
                  triggered_q <= 1'b1;
                  irst_q      <= 1'b1;
               end
            end else begin
               triggered_q <= 1'b0;
            end
         end
         // clear wins over a same-cycle set
         if (irst_clr)
            irst_q <= 1'b0;
         irq_q <= irst_q && erst_q;
      end
   end

   // read mux, unmapped addresses float high
   always_comb begin
      case (addr)
         vic_pkg::reg_ctrl1:  rd_data = {raster_line_i[8], 2'b00, den_q, 1'b0, yscroll_q};
         vic_pkg::reg_raster: rd_data = raster_line_i[7:0];
         vic_pkg::reg_irq:    rd_data = {irq_q, 6'b000000, irst_q};
         vic_pkg::reg_irq_en: rd_data = {7'b0000000, erst_q};
         default:             rd_data = 8'hff;
      endcase
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst)
         dbo_q <= '0;
      else
         dbo_q <= rd_data;
   end

   assign yscroll_o = yscroll_q;
   assign den_o     = den_q;
   assign irq_o     = irq_q;
   assign dbo_o     = dbo_q;

endmodule

/* design/vic_raster.sv */
`timescale 1ns/1ns

`include "vic_settings.svh"

module vic_raster (
   input  logic                   clk_dot4x,
   input  logic                   rst,
   input  vic_pkg::chip_e         chip_i,
   input  logic                   dot_tick_i,
   output vic_pkg::raster_x_t     raster_x_o,
   output vic_pkg::raster_line_t  raster_line_o
);

   vic_pkg::raster_x_t    x_max;
   vic_pkg::raster_line_t y_max;
   vic_pkg::raster_x_t    raster_x_q;
   vic_pkg::raster_line_t raster_line_q;
   logic                  x_wrap;
   logic                  y_wrap;

   // per chip line length and frame height
   always_comb begin
      case (chip_i)
         vic_pkg::chip_6567r8: begin
            // 520 pixels, 263 lines
            x_max = vic_pkg::raster_x_t'(`VIC_R8_X_MAX);
            y_max = vic_pkg::raster_line_t'(`VIC_R8_Y_MAX);
         end
         vic_pkg::chip_6567r56a: begin
            // 512 pixels, 262 lines
            x_max = vic_pkg::raster_x_t'(`VIC_R56A_X_MAX);
            y_max = vic_pkg::raster_line_t'(`VIC_R56A_Y_MAX);
         end
         default: begin
            // 6569 and the unused code, 504 pixels, 312 lines
            x_max = vic_pkg::raster_x_t'(`VIC_6569_X_MAX);
            y_max = vic_pkg::raster_line_t'(`VIC_6569_Y_MAX);
         end
      endcase
   end

   assign x_wrap = (raster_x_q == x_max);
   assign y_wrap = (raster_line_q == y_max);

   // one pixel per dot tick, line steps on x wrap
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x_q    <= '0;
         raster_line_q <= '0;
      end else if (dot_tick_i) begin
         if (x_wrap) begin
            raster_x_q <= '0;
            // frame wrap
            if (y_wrap)
               raster_line_q <= '0;
            else
               raster_line_q <= raster_line_q + 9'd1;
         end else begin
            raster_x_q <= raster_x_q + 10'd1;
         end
      end
   end

   assign raster_x_o    = raster_x_q;
   assign raster_line_o = raster_line_q;

endmodule

/* design/vic_phase_gen.sv */
`timescale 1ns/1ns

`include "vic_settings.svh"

module vic_phase_gen (
   input  logic       clk_dot4x,
   input  logic       rst,
   output logic       clk_phi_o,
   output logic       dot_tick_o,
   output logic       phi_rise_o,
   output logic [3:0] phase_tick_o
);

   // 32 ticks per phi period, 16 high and 16 low
   logic [31:0] phi_ring_q;
   // one bit set, rotates every dot4x tick
   logic [3:0]  dot_ring_q;
   // position within the current phi half
   logic [3:0]  phase_q;

   // phi comes out of bit 0, so it is already registered
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_ring_q <= `VIC_PHI_RING_INIT;
         dot_ring_q <= `VIC_DOT_RING_INIT;
         phase_q    <= `VIC_PHASE_INIT;
      end else begin
         phi_ring_q <= {phi_ring_q[30:0], phi_ring_q[31]};
         dot_ring_q <= {dot_ring_q[2:0], dot_ring_q[3]};
         // wraps at 16, lined up with each phi edge
         phase_q    <= phase_q + 4'd1;
      end
   end

   assign clk_phi_o    = phi_ring_q[0];
   assign dot_tick_o   = dot_ring_q[0];
   assign phase_tick_o = phase_q;

   // first tick of a phi-high half
   assign phi_rise_o = phi_ring_q[0] && (phase_q == 4'd0);

endmodule

/* design/vic_pkg.sv */
package vic_pkg;

   // chip select pins, unused code behaves as 6569
   typedef enum logic [1:0] {
      chip_6567r56a = 2'd0,
      chip_6567r8   = 2'd1,
      chip_6569     = 2'd2,
      chip_unused   = 2'd3
   } chip_e;

   // cpu visible registers kept by the timing core
   typedef enum logic [5:0] {
      reg_ctrl1  = 6'h11,
      reg_raster = 6'h12,
      reg_irq    = 6'h19,
      reg_irq_en = 6'h1a
   } reg_addr_e;

   // pixel position within a raster line
   typedef logic [9:0] raster_x_t;

   // raster line, up to 312 lines on pal
   typedef logic [8:0] raster_line_t;

   // cycle number, raster_x / 8
   typedef logic [6:0] cycle_num_t;

endpackage

/* design/vic_settings.svh */
`ifndef VIC_SETTINGS_SVH
`define VIC_SETTINGS_SVH

// last raster_x value of a line, per chip
`define VIC_R8_X_MAX 519
`define VIC_R56A_X_MAX 511
`define VIC_6569_X_MAX 503

// last raster line of a frame, per chip
`define VIC_R8_Y_MAX 262
`define VIC_R56A_Y_MAX 261
`define VIC_6569_Y_MAX 311

// badline range, first line doubles as the den sampling line
`define VIC_BADLINE_FIRST 48
`define VIC_BADLINE_END 248

// inclusive cycle window where character fetches pull ba low
`define VIC_BA_FIRST_CYCLE 12
`define VIC_BA_LAST_CYCLE 54

// tick within a phi half where cpu write data is stable
`define VIC_DATA_DAV 7

// phi-high edges ba must stay low before aec is held off
`define VIC_AEC_DELAY 3

// ring and phase counter start values out of reset
// phi ring: bits 20..5 set, phi rises after 12 rotations
`define VIC_PHI_RING_INIT 32'h001f_ffe0
`define VIC_DOT_RING_INIT 4'b1000
`define VIC_PHASE_INIT 4'd4

`endif
